//--- vlog.f
rtl/mapper_pkg.sv
rtl/cpu_write_decode.sv
rtl/bank_regs.sv
rtl/prg_map.sv
rtl/chr_map.sv
rtl/discrete_mapper.sv
testbench/mapper_checker.sv
testbench/tb_discrete_mapper.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the discrete mapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
	--top-module tb_discrete_mapper -o tb_sim

out="$(./obj_dir/tb_sim)"
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1

//--- testbench/tb_discrete_mapper.sv
// Testbench top for the discrete mapper, random stimulus from a fixed seed
// Board flags change only while arst_n is low; the checker module does all comparing
`timescale 1ns/1ps

module tb_discrete_mapper;

	localparam int RESET_CYCLES = 8;
	localparam int SETUP_CYCLES = RESET_CYCLES + 1;  // Reset plus the aligning edge
	localparam int STIM_CYCLES  = 400;
	localparam int PROBE_CYCLES = 8;   // Read-only cycles per board in the reset test
	localparam int N_TESTS      = 6;
	// Three full boards, two split tests of two boards, seven reset probes, end pulses, verdict
	localparam int RUN_CYCLES   = 3 * (SETUP_CYCLES + STIM_CYCLES)
		+ 4 * (SETUP_CYCLES + STIM_CYCLES / 2) + 7 * (SETUP_CYCLES + PROBE_CYCLES)
		+ N_TESTS + 1;
	localparam int CYCLE_LIMIT  = RUN_CYCLES + RUN_CYCLES / 4;  // 25 % margin

	// Board indices, local to the testbench
	localparam int B_NROM = 0;
	localparam int B_GX   = 1;
	localparam int B_CD   = 2;
	localparam int B_BX   = 3;
	localparam int B_N1   = 4;
	localparam int B_N3   = 5;
	localparam int B_N6   = 6;

	logic                    clk;
	logic                    arst_n;
	logic                    ce;
	mapper_pkg::cart_flags_t flags;
	mapper_pkg::cpu_bus_t    cpu;
	logic [13:0]             chr_addr;
	mapper_pkg::prg_out_t    prg;
	mapper_pkg::chr_out_t    chr;
	logic [3:0]              test_num;
	logic                    test_end;  // One pulse per finished test
	int                      checks;
	int                      errors;
	integer                  seed;
	int                      cycles = 0;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	discrete_mapper u_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.ce       (ce),
		.flags    (flags),
		.cpu      (cpu),
		.chr_addr (chr_addr),
		.prg      (prg),
		.chr      (chr)
	);

	mapper_checker u_checker (
		.clk      (clk),
		.arst_n   (arst_n),
		.ce       (ce),
		.flags    (flags),
		.cpu      (cpu),
		.chr_addr (chr_addr),
		.prg      (prg),
		.chr      (chr),
		.test_num (test_num),
		.test_end (test_end),
		.checks   (checks),
		.errors   (errors)
	);

	function automatic mapper_pkg::cart_flags_t board_flags(input int board);
		mapper_pkg::cart_flags_t f;
		f = '0;
		case (board)
			B_GX: f.mapper_id = mapper_pkg::MAP_GXROM;
			B_CD: begin
				f.mapper_id = mapper_pkg::MAP_COLOR_DREAMS;
				f.chr_ram   = 1'b1;
			end
			B_BX: begin
				f.mapper_id = mapper_pkg::MAP_BNROM;  // CHR size 0 means BxROM
				f.chr_ram   = 1'b1;
			end
			B_N1: begin
				f.mapper_id    = mapper_pkg::MAP_BNROM;
				f.chr_rom_size = 3'd2;  // NINA-001
			end
			B_N3: begin
				f.mapper_id       = mapper_pkg::MAP_NINA03;
				f.vertical_mirror = 1'b1;
			end
			B_N6: begin
				f.mapper_id       = mapper_pkg::MAP_NINA06;
				f.vertical_mirror = 1'b1;  // Ignored, register decides
			end
			default: begin
				f.mapper_id       = mapper_pkg::MAP_NROM;
				f.vertical_mirror = 1'b1;
			end
		endcase
		return f;
	endfunction

	task automatic apply_reset(input int board);
		@(posedge clk);
		#1;
		arst_n = 1'b0;
		ce     = 1'b0;
		cpu    = '0;
		flags  = board_flags(board);  // Swap board only inside reset
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;
	endtask

	task automatic drive_random(input int board, input int n, input bit writes);
		logic [31:0] r_addr;
		logic [31:0] r_ctl;
		logic [15:0] addr;
		repeat (n) begin
			@(posedge clk);
			#1;
			r_addr = $random(seed);
			r_ctl  = $random(seed);
			addr   = r_addr[15:0];
			if (r_ctl[4]) begin  // Aim at the register decode half the time
				case (board)
					B_GX, B_CD, B_BX: addr[15] = 1'b1;
					B_N1: begin
						if (r_ctl[5]) begin
							addr = {3'b011, r_addr[12:0]};  // RAM window
						end else if (r_ctl[7:6] == 2'd0) begin
							addr = mapper_pkg::NINA_REG_PRG;
						end else if (r_ctl[7:6] == 2'd1) begin
							addr = mapper_pkg::NINA_REG_CHR0;
						end else begin
							addr = mapper_pkg::NINA_REG_CHR1;
						end
					end
					B_N3, B_N6: begin
						addr[15:13] = 3'b010;  // $4100 style decode
						addr[8]     = 1'b1;
					end
					default: ;
				endcase
			end
			cpu.addr  = addr;
			cpu.write = r_ctl[0];
			cpu.din   = r_ctl[15:8];
			ce        = writes && (r_ctl[3:2] != 2'b00);  // About 3/4 high
			chr_addr  = r_ctl[29:16];
		end
	endtask

	task automatic run_board(input int board, input int n);
		apply_reset(board);
		drive_random(board, n, 1'b1);
	endtask

	task automatic end_test(input logic [3:0] num);
		@(posedge clk);
		#1;
		test_num = num;
		test_end = 1'b1;
		#1;
		test_end = 1'b0;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no verdict after %0d clock cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		seed     = 39;
		arst_n   = 1'b0;
		ce       = 1'b0;
		flags    = board_flags(B_NROM);
		cpu      = '0;
		chr_addr = '0;
		test_num = 4'd0;
		test_end = 1'b0;

		run_board(B_NROM, STIM_CYCLES);
		end_test(4'd1);
		run_board(B_GX, STIM_CYCLES);
		end_test(4'd2);
		run_board(B_CD, STIM_CYCLES);
		end_test(4'd3);
		run_board(B_BX, STIM_CYCLES / 2);
		run_board(B_N1, STIM_CYCLES / 2);
		end_test(4'd4);
		run_board(B_N3, STIM_CYCLES / 2);
		run_board(B_N6, STIM_CYCLES / 2);
		end_test(4'd5);
		for (int b = B_NROM; b <= B_N6; b++) begin
			apply_reset(b);
			drive_random(b, PROBE_CYCLES, 1'b0);  // ce low, banks stay at reset
		end
		end_test(4'd6);

		@(posedge clk);
		#1;
		$display("Totals: %0d tests, %0d cycles checked, %0d mismatches", N_TESTS, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- testbench/mapper_checker.sv
// Reference model of the mapper with its own shadow registers
// Compares at the falling edge, once the stimulus from the rising edge has settled
`timescale 1ns/1ps

module mapper_checker (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    ce,
	input  mapper_pkg::cart_flags_t flags,
	input  mapper_pkg::cpu_bus_t    cpu,
	input  logic [13:0]             chr_addr,
	input  mapper_pkg::prg_out_t    prg,
	input  mapper_pkg::chr_out_t    chr,
	input  logic [3:0]              test_num,
	input  logic                    test_end,
	output int                      checks,
	output int                      errors
);

	logic [5:0]  s_prg;   // Shadow banks
	logic [3:0]  s_chr0;
	logic [3:0]  s_chr1;
	logic        s_mir;
	logic        is_gx, is_cd, is_bx, is_n1, is_n3, is_n6;
	logic [21:0] exp_prg_aout;
	logic        exp_prg_allow;
	logic [21:0] exp_chr_aout;
	logic [3:0]  bank_4k;
	logic        vertical;
	int          n_checks = 0;
	int          n_errors = 0;
	int          checks_mark = 0;
	int          errors_mark = 0;

	assign checks = n_checks;
	assign errors = n_errors;

	assign is_gx = flags.mapper_id == mapper_pkg::MAP_GXROM;
	assign is_cd = flags.mapper_id == mapper_pkg::MAP_COLOR_DREAMS;
	assign is_bx = (flags.mapper_id == mapper_pkg::MAP_BNROM) && (flags.chr_rom_size == 3'd0);
	assign is_n1 = (flags.mapper_id == mapper_pkg::MAP_BNROM) && (flags.chr_rom_size != 3'd0);
	assign is_n3 = flags.mapper_id == mapper_pkg::MAP_NINA03;
	assign is_n6 = flags.mapper_id == mapper_pkg::MAP_NINA06;

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s_prg  <= 6'd0;
			s_chr0 <= 4'd0;
			s_chr1 <= 4'd1;  // BxROM upper half
			s_mir  <= 1'b0;
		end else if (ce && cpu.write) begin
			if (is_gx && cpu.addr[15]) begin
				s_prg  <= {4'b0000, cpu.din[5:4]};
				s_chr0 <= {2'b00, cpu.din[1:0]};
			end
			if (is_cd && cpu.addr[15]) begin
				s_prg  <= {4'b0000, cpu.din[1:0]};
				s_chr0 <= cpu.din[7:4];
			end
			if (is_bx && cpu.addr[15])
				s_prg <= cpu.din[5:0];
			if (is_n1 && cpu.addr == 16'h7FFD)
				s_prg <= cpu.din[5:0];
			if (is_n1 && cpu.addr == 16'h7FFE)
				s_chr0 <= cpu.din[3:0];
			if (is_n1 && cpu.addr == 16'h7FFF)
				s_chr1 <= cpu.din[3:0];
			if ((is_n3 || is_n6) && cpu.addr[15:13] == 3'b010 && cpu.addr[8]) begin
				s_prg  <= {3'b000, cpu.din[5:3]};
				s_chr0 <= {cpu.din[6], cpu.din[2:0]};
				s_mir  <= cpu.din[7];
			end
		end
	end

	always_comb begin
		if (is_n1 && cpu.addr[15:13] == 3'b011) begin  // Work RAM, reads and writes
			exp_prg_aout  = mapper_pkg::PRG_RAM_BASE + {9'd0, cpu.addr[12:0]};
			exp_prg_allow = 1'b1;
		end else begin
			exp_prg_aout  = {1'b0, s_prg, cpu.addr[14:0]};
			exp_prg_allow = cpu.addr[15] & ~cpu.write;
		end
		bank_4k = chr_addr[12] ? s_chr1 : s_chr0;
		if (is_bx || is_n1)
			exp_chr_aout = mapper_pkg::CHR_BASE + {6'd0, bank_4k, chr_addr[11:0]};
		else
			exp_chr_aout = mapper_pkg::CHR_BASE + {5'd0, s_chr0, chr_addr[12:0]};
		vertical = is_n6 ? s_mir : flags.vertical_mirror;
	end

	task automatic compare_addr(input string name, input logic [21:0] exp_v,
		input logic [21:0] act_v);
		if (exp_v !== act_v) begin
			n_errors = n_errors + 1;
			$display("FAILED %s expected 0x%06h got 0x%06h at %0t", name, exp_v, act_v, $time);
		end
	endtask

	task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
		if (exp_v !== act_v) begin
			n_errors = n_errors + 1;
			$display("FAILED %s expected 0x%0h got 0x%0h at %0t", name, exp_v, act_v, $time);
		end
	endtask

	always @(negedge clk) begin
		n_checks = n_checks + 1;
		compare_addr("prg.aout", exp_prg_aout, prg.aout);
		compare_bit("prg.allow", exp_prg_allow, prg.allow);
		compare_addr("chr.aout", exp_chr_aout, chr.aout);
		compare_bit("chr.allow", flags.chr_ram, chr.allow);
		compare_bit("chr.vram_a10", vertical ? chr_addr[10] : chr_addr[11], chr.vram_a10);
		compare_bit("chr.vram_ce", chr_addr[13], chr.vram_ce);
	end

	function automatic string test_name(input logic [3:0] n);
		case (n)
			4'd1:    return "NROM";
			4'd2:    return "GxROM";
			4'd3:    return "Color Dreams";
			4'd4:    return "BxROM and NINA-001";
			4'd5:    return "NINA-03 and NINA-06";
			4'd6:    return "reset values";
			default: return "unknown";
		endcase
	endfunction

	always @(posedge test_end) begin
		$display("Test %0d %s: %0d cycles checked, %0d mismatches", test_num,
			test_name(test_num), n_checks - checks_mark, n_errors - errors_mark);
		checks_mark = n_checks;
		errors_mark = n_errors;
	end

endmodule

//--- rtl/discrete_mapper.sv
// Top level of the discrete mapper address logic
// flags must stay stable outside reset; writes are ce-qualified strobes
`timescale 1ns/1ps

module discrete_mapper (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          ce,        // CPU M2 enable
	input  mapper_pkg::cart_flags_t       flags,
	input  mapper_pkg::cpu_bus_t          cpu,
	input  logic [mapper_pkg::PPU_AW-1:0] chr_addr,
	output mapper_pkg::prg_out_t          prg,
	output mapper_pkg::chr_out_t          chr
);

	mapper_pkg::mapper_kind_e kind;   // Board type, static after reset
	mapper_pkg::reg_load_t    load;   // Decoded register writes
	mapper_pkg::bank_state_t  state;  // Current banks and mirroring

	cpu_write_decode u_decode (
		.cpu   (cpu),
		.ce    (ce),
		.flags (flags),
		.kind  (kind),
		.load  (load)
	);

	bank_regs u_regs (
		.clk    (clk),
		.arst_n (arst_n),
		.load   (load),
		.state  (state)
	);

	prg_map u_prg (
		.cpu   (cpu),
		.kind  (kind),
		.state (state),
		.prg   (prg)
	);

	chr_map u_chr (
		.chr_addr (chr_addr),
		.flags    (flags),
		.kind     (kind),
		.state    (state),
		.chr      (chr)
	);

endmodule

//--- rtl/chr_map.sv
// PPU side address translation and nametable mirroring, combinational
// BxROM and NINA-001 use two 4 KB banks, all other boards one 8 KB bank
`timescale 1ns/1ps

module chr_map (
	input  logic [mapper_pkg::PPU_AW-1:0] chr_addr,
	input  mapper_pkg::cart_flags_t       flags,
	input  mapper_pkg::mapper_kind_e      kind,
	input  mapper_pkg::bank_state_t       state,
	output mapper_pkg::chr_out_t          chr
);

	localparam int PAD_4K = mapper_pkg::MEM_AW - mapper_pkg::CHR_BANK_W - 12;
	localparam int PAD_8K = mapper_pkg::MEM_AW - mapper_pkg::CHR_BANK_W - 13;

	logic                              split_4k;
	logic [mapper_pkg::CHR_BANK_W-1:0] bank_4k;
	logic [mapper_pkg::MEM_AW-1:0]     offset;
	logic                              vertical;

	assign split_4k = (kind == mapper_pkg::BXROM) || (kind == mapper_pkg::NINA001);
	assign bank_4k  = chr_addr[12] ? state.chr_bank_1 : state.chr_bank_0;  // $1000 half

	always_comb begin
		if (split_4k) begin
			offset = {{PAD_4K{1'b0}}, bank_4k, chr_addr[11:0]};
		end else begin
			offset = {{PAD_8K{1'b0}}, state.chr_bank_0, chr_addr[12:0]};
		end
	end

	// NINA-06 mirroring comes from the register, others from the header
	assign vertical = (kind == mapper_pkg::NINA06) ? state.mirroring : flags.vertical_mirror;

	always_comb begin
		chr.aout     = mapper_pkg::CHR_BASE + offset;
		chr.allow    = flags.chr_ram;                            // Writes only to CHR RAM
		chr.vram_ce  = chr_addr[13];                             // Nametable space
		chr.vram_a10 = vertical ? chr_addr[10] : chr_addr[11];  // Vertical uses A10
	end

endmodule

//--- rtl/prg_map.sv
// CPU side address translation, combinational with zero latency
// Only NINA-001 opens the $6000-$7FFF RAM window
`timescale 1ns/1ps

module prg_map (
	input  mapper_pkg::cpu_bus_t     cpu,
	input  mapper_pkg::mapper_kind_e kind,
	input  mapper_pkg::bank_state_t  state,
	output mapper_pkg::prg_out_t     prg
);

	localparam int ROM_PAD = mapper_pkg::MEM_AW - mapper_pkg::PRG_BANK_W - 15;

	logic [mapper_pkg::PRG_BANK_W-1:0] bank_mask;
	logic [mapper_pkg::PRG_BANK_W-1:0] bank;
	logic [mapper_pkg::MEM_AW-1:0]     rom_addr;
	logic [mapper_pkg::MEM_AW-1:0]     ram_addr;
	logic                              ram_hit;
	logic                              rom_read;

	// Bank bits each board actually drives
	always_comb begin
		case (kind)
			mapper_pkg::GXROM, mapper_pkg::COLOR_DREAMS: bank_mask = 6'b000011;
			mapper_pkg::BXROM, mapper_pkg::NINA001:      bank_mask = 6'b111111;
			mapper_pkg::NINA03, mapper_pkg::NINA06:      bank_mask = 6'b000111;
			default:                                     bank_mask = 6'b000000;  // NROM
		endcase
	end

	assign bank     = state.prg_bank & bank_mask;
	assign rom_addr = {{ROM_PAD{1'b0}}, bank, cpu.addr[14:0]};  // 32 KB pages

	assign ram_hit  = (kind == mapper_pkg::NINA001) && (cpu.addr[15:13] == 3'b011);
	assign ram_addr = mapper_pkg::PRG_RAM_BASE
		+ {{(mapper_pkg::MEM_AW-13){1'b0}}, cpu.addr[12:0]};  // 8 KB window

	assign rom_read = cpu.addr[15] & ~cpu.write;  // ROM is read only

	always_comb begin
		prg.aout  = ram_hit ? ram_addr : rom_addr;
		prg.allow = ram_hit | rom_read;  // RAM takes reads and writes
	end

endmodule

//--- rtl/bank_regs.sv
// Bank and mirroring registers, one-cycle update after a qualifying write
// chr_bank_1 resets to 1 so BxROM sees the upper 4 KB CHR half
`timescale 1ns/1ps

module bank_regs (
	input  logic                    clk,
	input  logic                    arst_n,
	input  mapper_pkg::reg_load_t   load,
	output mapper_pkg::bank_state_t state
);

	logic [mapper_pkg::PRG_BANK_W-1:0] prg_bank;
	logic [mapper_pkg::CHR_BANK_W-1:0] chr_bank_0;
	logic [mapper_pkg::CHR_BANK_W-1:0] chr_bank_1;
	logic                              mirroring;

	// PRG bank, 32 KB window at $8000
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prg_bank <= '0;
		end else if (load.ld_prg) begin
			prg_bank <= load.prg;
		end
	end

	// Low CHR bank, or the whole 8 KB bank
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			chr_bank_0 <= '0;
		end else if (load.ld_chr0) begin
			chr_bank_0 <= load.chr0;
		end
	end

	// High 4 KB CHR bank
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			chr_bank_1 <= 4'd1;  // BxROM default
		end else if (load.ld_chr1) begin
			chr_bank_1 <= load.chr1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mirroring <= 1'b0;  // Horizontal
		end else if (load.ld_mirror) begin
			mirroring <= load.mirroring;
		end
	end

	assign state.prg_bank   = prg_bank;
	assign state.chr_bank_0 = chr_bank_0;
	assign state.chr_bank_1 = chr_bank_1;
	assign state.mirroring  = mirroring;

endmodule

//--- rtl/cpu_write_decode.sv
// Board classification and CPU register write decode, purely combinational
// Strobes are valid only while ce is high; the registers sample them on clk
`timescale 1ns/1ps

module cpu_write_decode (
	input  mapper_pkg::cpu_bus_t     cpu,
	input  logic                     ce,
	input  mapper_pkg::cart_flags_t  flags,
	output mapper_pkg::mapper_kind_e kind,
	output mapper_pkg::reg_load_t    load
);

	mapper_pkg::write_byte_u wb;  // Same byte, board-specific layouts
	logic                    wr;  // Qualified write strobe
	logic                    nina_hit;

	assign wb       = cpu.din;
	assign wr       = ce & cpu.write;
	assign nina_hit = (cpu.addr[15:13] == 3'b010) & cpu.addr[8];  // $4100 mirror decode

	always_comb begin
		case (flags.mapper_id)
			mapper_pkg::MAP_NROM:         kind = mapper_pkg::NROM;
			mapper_pkg::MAP_COLOR_DREAMS: kind = mapper_pkg::COLOR_DREAMS;
			mapper_pkg::MAP_GXROM:        kind = mapper_pkg::GXROM;
			mapper_pkg::MAP_NINA03:       kind = mapper_pkg::NINA03;
			mapper_pkg::MAP_NINA06:       kind = mapper_pkg::NINA06;
			mapper_pkg::MAP_BNROM:
				kind = (flags.chr_rom_size != 3'd0) ? mapper_pkg::NINA001 : mapper_pkg::BXROM;
			default:                      kind = mapper_pkg::NROM;  // Unknown boards act as NROM
		endcase
	end

	always_comb begin
		load = '0;
		case (kind)
			mapper_pkg::GXROM: begin
				if (wr && cpu.addr[15]) begin
					load.ld_prg  = 1'b1;
					load.ld_chr0 = 1'b1;
					load.prg     = {4'b0000, wb.gxrom_v.prg};
					load.chr0    = {2'b00, wb.gxrom_v.chr};
				end
			end
			mapper_pkg::COLOR_DREAMS: begin
				if (wr && cpu.addr[15]) begin
					load.ld_prg  = 1'b1;
					load.ld_chr0 = 1'b1;
					load.prg     = {4'b0000, wb.color_dreams_v.prg};
					load.chr0    = wb.color_dreams_v.chr;
				end
			end
			mapper_pkg::BXROM: begin
				load.ld_prg = wr & cpu.addr[15];
				load.prg    = cpu.din[5:0];  // Oversize 6-bit bank
			end
			mapper_pkg::NINA001: begin
				load.ld_prg  = wr && (cpu.addr == mapper_pkg::NINA_REG_PRG);
				load.ld_chr0 = wr && (cpu.addr == mapper_pkg::NINA_REG_CHR0);
				load.ld_chr1 = wr && (cpu.addr == mapper_pkg::NINA_REG_CHR1);
				load.prg     = cpu.din[5:0];
				load.chr0    = cpu.din[3:0];
				load.chr1    = cpu.din[3:0];
			end
			mapper_pkg::NINA03, mapper_pkg::NINA06: begin
				if (wr && nina_hit) begin
					load.ld_prg    = 1'b1;
					load.ld_chr0   = 1'b1;
					load.ld_mirror = 1'b1;  // Only NINA-06 uses it downstream
					load.prg       = {3'b000, wb.nina03_v.prg};
					load.chr0      = {wb.nina03_v.chr_hi, wb.nina03_v.chr_lo};
					load.mirroring = wb.nina03_v.mirroring;
				end
			end
			default: ;  // NROM has no registers
		endcase
	end

endmodule

//--- rtl/mapper_pkg.sv
// Shared types and constants for the discrete mapper address logic
// Cart flags are expected to change only while arst_n is low
package mapper_pkg;

	localparam int CPU_AW     = 16;  // CPU address bus
	localparam int PPU_AW     = 14;  // PPU address bus
	localparam int MEM_AW     = 22;  // Cartridge memory space
	localparam int PRG_BANK_W = 6;   // Widest PRG bank, BxROM oversize
	localparam int CHR_BANK_W = 4;   // Widest CHR bank

	localparam logic [MEM_AW-1:0] CHR_BASE     = 22'h200000;  // Top bit set for CHR space
	localparam logic [MEM_AW-1:0] PRG_RAM_BASE = 22'h3C0000;  // NINA-001 work RAM

	localparam logic [CPU_AW-1:0] NINA_REG_PRG  = 16'h7FFD;
	localparam logic [CPU_AW-1:0] NINA_REG_CHR0 = 16'h7FFE;
	localparam logic [CPU_AW-1:0] NINA_REG_CHR1 = 16'h7FFF;

	localparam logic [7:0] MAP_NROM         = 8'd0;
	localparam logic [7:0] MAP_COLOR_DREAMS = 8'd11;
	localparam logic [7:0] MAP_BNROM        = 8'd34;   // Also NINA-001, split by CHR size
	localparam logic [7:0] MAP_GXROM        = 8'd66;
	localparam logic [7:0] MAP_NINA03       = 8'd79;
	localparam logic [7:0] MAP_NINA06       = 8'd113;

	// NINA03 and NINA06 share the write decode
	typedef enum logic [2:0] {
		NROM,
		COLOR_DREAMS,
		BXROM,
		NINA001,
		GXROM,
		NINA03,
		NINA06
	} mapper_kind_e;

	typedef struct packed {
		logic [7:0] mapper_id;     // iNES mapper number
		logic [2:0] chr_rom_size;  // Nonzero picks NINA-001 on #34
		logic       vertical_mirror;
		logic       chr_ram;       // CHR is writable RAM
	} cart_flags_t;

	typedef struct packed {
		logic [CPU_AW-1:0] addr;
		logic              write;
		logic [7:0]        din;
	} cpu_bus_t;

	typedef struct packed {
		logic [MEM_AW-1:0] aout;
		logic              allow;  // Access permitted for this cycle
	} prg_out_t;

	typedef struct packed {
		logic [MEM_AW-1:0] aout;
		logic              allow;
		logic              vram_a10;  // Nametable page select
		logic              vram_ce;   // Route to internal 2 KB VRAM
	} chr_out_t;

	typedef struct packed {
		logic                  ld_prg;
		logic                  ld_chr0;
		logic                  ld_chr1;
		logic                  ld_mirror;
		logic [PRG_BANK_W-1:0] prg;
		logic [CHR_BANK_W-1:0] chr0;
		logic [CHR_BANK_W-1:0] chr1;
		logic                  mirroring;
	} reg_load_t;

	typedef struct packed {
		logic [PRG_BANK_W-1:0] prg_bank;
		logic [CHR_BANK_W-1:0] chr_bank_0;
		logic [CHR_BANK_W-1:0] chr_bank_1;
		logic                  mirroring;  // 1 selects vertical
	} bank_state_t;

	typedef union packed {
		struct packed {
			logic [1:0] rsvd_hi;
			logic [1:0] prg;
			logic [1:0] rsvd_lo;
			logic [1:0] chr;
		} gxrom_v;
		struct packed {
			logic [3:0] chr;
			logic [1:0] rsvd;
			logic [1:0] prg;
		} color_dreams_v;
		struct packed {
			logic       mirroring;
			logic       chr_hi;   // CHR bank bit 3
			logic [2:0] prg;
			logic [2:0] chr_lo;   // CHR bank bits 2:0
		} nina03_v;
	} write_byte_u;

endpackage
